// File: csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    localparam int csr_num_w = 14;

    // register numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_num_w-1:0] csr_ecfg   = 14'h004;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h007;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h031;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h032;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h033;
    localparam logic [csr_num_w-1:0] csr_tid    = 14'h040;
    localparam logic [csr_num_w-1:0] csr_tcfg   = 14'h041;
    localparam logic [csr_num_w-1:0] csr_tval   = 14'h042;
    localparam logic [csr_num_w-1:0] csr_ticlr  = 14'h044;

    // field positions
    localparam int crmd_plv_lo       = 0;
    localparam int crmd_plv_hi       = 1;
    localparam int crmd_ie           = 2;
    localparam int crmd_da           = 3;
    localparam int prmd_pplv_lo      = 0;
    localparam int prmd_pplv_hi      = 1;
    localparam int prmd_pie          = 2;
    localparam int ecfg_lie_lo       = 0;
    localparam int ecfg_lie_hi       = 12;
    localparam int estat_is_lo       = 0;
    localparam int estat_is_hi       = 12;
    localparam int estat_ecode_lo    = 16;
    localparam int estat_ecode_hi    = 21;
    localparam int estat_esubcode_lo = 22;
    localparam int estat_esubcode_hi = 30;
    localparam int eentry_va_lo      = 6;
    localparam int eentry_va_hi      = 31;
    localparam int tcfg_en           = 0;
    localparam int tcfg_periodic     = 1;
    localparam int tcfg_initval_lo   = 2;
    localparam int tcfg_initval_hi   = 31;
    localparam int ticlr_clr         = 0;

endpackage

`default_nettype wire

// File: exc_pkg.sv
`default_nettype none

package exc_pkg;

    localparam int xlen       = 32;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    localparam int plv_w      = 2;

    localparam logic [plv_w-1:0] plv_kernel = 2'd0; // trap target level

    // exception codes
    localparam logic [ecode_w-1:0] ecode_int = 6'h00;
    localparam logic [ecode_w-1:0] ecode_ade = 6'h08;
    localparam logic [ecode_w-1:0] ecode_ale = 6'h09;
    localparam logic [ecode_w-1:0] ecode_sys = 6'h0b;
    localparam logic [ecode_w-1:0] ecode_brk = 6'h0c;
    localparam logic [ecode_w-1:0] ecode_ine = 6'h0d;

    localparam logic [xlen-1:0] timer_idle = 32'hffff_ffff; // count parked here when stopped
    localparam int timer_int_bit = 11;

endpackage

`default_nettype wire

// File: exc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exc_ctrl (
    input  wire                               clk,
    input  wire                               reset,
    input  wire  [csr_addr_pkg::csr_num_w-1:0] csr_num,
    input  wire                               csr_we,
    input  wire  [exc_pkg::xlen-1:0]          csr_wmask,
    input  wire  [exc_pkg::xlen-1:0]          csr_wvalue,
    input  wire                               wb_ex,
    input  wire                               ertn_flush,
    input  wire  [exc_pkg::ecode_w-1:0]       wb_ecode,
    input  wire  [exc_pkg::esubcode_w-1:0]    wb_esubcode,
    input  wire  [exc_pkg::xlen-1:0]          wb_pc,
    input  wire  [exc_pkg::xlen-1:0]          wb_vaddr,
    input  wire                               timer_int,
    output logic [exc_pkg::xlen-1:0]          crmd_rdata,
    output logic [exc_pkg::xlen-1:0]          prmd_rdata,
    output logic [exc_pkg::xlen-1:0]          ecfg_rdata,
    output logic [exc_pkg::xlen-1:0]          estat_rdata,
    output logic [exc_pkg::xlen-1:0]          badv_rdata,
    output logic [exc_pkg::xlen-1:0]          ertn_entry,
    output logic [exc_pkg::plv_w-1:0]         crmd_plv,
    output logic                              has_int
);
    import csr_addr_pkg::*;
    import exc_pkg::*;

    logic [plv_w-1:0]                     plv;
    logic                                 ie;
    logic                                 da;
    logic [plv_w-1:0]                     pplv;
    logic                                 pie;
    logic [ecfg_lie_hi:ecfg_lie_lo]       lie;
    logic [1:0]                           swi;      // software interrupt bits
    logic [ecode_w-1:0]                   ecode;
    logic [esubcode_w-1:0]                esubcode;
    logic [xlen-1:0]                      era;
    logic [xlen-1:0]                      badv;
    logic [estat_is_hi:estat_is_lo]       int_lines;
    logic [xlen-1:0] crmd_next, prmd_next, ecfg_next, estat_next, era_next, badv_next;
    logic            addr_err;

    always_comb begin
        crmd_rdata = '0;
        crmd_rdata[crmd_plv_hi:crmd_plv_lo] = plv;
        crmd_rdata[crmd_ie] = ie;
        crmd_rdata[crmd_da] = da;
        prmd_rdata = '0;
        prmd_rdata[prmd_pplv_hi:prmd_pplv_lo] = pplv;
        prmd_rdata[prmd_pie] = pie;
        ecfg_rdata = '0;
        ecfg_rdata[ecfg_lie_hi:ecfg_lie_lo] = lie;
        int_lines = '0;
        int_lines[1:0] = swi;
        int_lines[timer_int_bit] = timer_int;
        estat_rdata = '0;
        estat_rdata[estat_is_hi:estat_is_lo] = int_lines;
        estat_rdata[estat_ecode_hi:estat_ecode_lo] = ecode;
        estat_rdata[estat_esubcode_hi:estat_esubcode_lo] = esubcode;
    end

    assign badv_rdata = badv;
    assign ertn_entry = era;
    assign crmd_plv   = plv;

    // masked merge of the software write with the current value
    assign crmd_next  = (csr_wmask & csr_wvalue) | (~csr_wmask & crmd_rdata);
    assign prmd_next  = (csr_wmask & csr_wvalue) | (~csr_wmask & prmd_rdata);
    assign ecfg_next  = (csr_wmask & csr_wvalue) | (~csr_wmask & ecfg_rdata);
    assign estat_next = (csr_wmask & csr_wvalue) | (~csr_wmask & estat_rdata);
    assign era_next   = (csr_wmask & csr_wvalue) | (~csr_wmask & era);
    assign badv_next  = (csr_wmask & csr_wvalue) | (~csr_wmask & badv);

    assign addr_err = (wb_ecode == ecode_ale) || (wb_ecode == ecode_ade);

    // ipi line 12 never counts
    assign has_int = ie && |(int_lines[timer_int_bit:0] & lie[timer_int_bit:0]);

    // privilege level and global enable
    always_ff @(posedge clk) begin
        if (reset) begin
            plv <= plv_kernel;
            ie  <= 1'b0;
        end else if (wb_ex) begin
            plv <= plv_kernel;
            ie  <= 1'b0;
        end else if (ertn_flush) begin
            plv <= pplv;
            ie  <= pie;
        end else if (csr_we && csr_num == csr_crmd) begin
            plv <= crmd_next[crmd_plv_hi:crmd_plv_lo];
            ie  <= crmd_next[crmd_ie];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            da <= 1'b1;
        end else if (csr_we && csr_num == csr_crmd) begin
            da <= crmd_next[crmd_da];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pplv     <= '0;
            pie      <= 1'b0;
            ecode    <= '0;
            esubcode <= '0;
            era      <= '0;
            badv     <= '0;
        end else if (wb_ex) begin
            pplv     <= plv;
            pie      <= ie;
            ecode    <= wb_ecode;
            esubcode <= wb_esubcode;
            era      <= wb_pc;
            if (addr_err) begin
                badv <= wb_vaddr;
            end
        end else if (csr_we) begin
            if (csr_num == csr_prmd) begin
                pplv <= prmd_next[prmd_pplv_hi:prmd_pplv_lo];
                pie  <= prmd_next[prmd_pie];
            end
            if (csr_num == csr_era) era <= era_next;
            if (csr_num == csr_badv) badv <= badv_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lie <= '0;
            swi <= '0;
        end else if (csr_we) begin
            if (csr_num == csr_ecfg) lie <= ecfg_next[ecfg_lie_hi:ecfg_lie_lo];
            if (csr_num == csr_estat) swi <= estat_next[estat_is_lo+1:estat_is_lo];
        end
    end

endmodule

`default_nettype wire

// File: csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  wire                               clk,
    input  wire                               reset,
    input  wire  [csr_addr_pkg::csr_num_w-1:0] csr_num,
    input  wire                               csr_we,
    input  wire  [exc_pkg::xlen-1:0]          csr_wmask,
    input  wire  [exc_pkg::xlen-1:0]          csr_wvalue,
    output logic [exc_pkg::xlen-1:0]          tcfg_rdata,
    output logic [exc_pkg::xlen-1:0]          tval_rdata,
    output logic                              timer_int
);
    import csr_addr_pkg::*;
    import exc_pkg::*;

    logic                                 en;
    logic                                 periodic;
    logic [tcfg_initval_hi:tcfg_initval_lo] initval;
    logic [xlen-1:0]                      count;
    logic [xlen-1:0]                      tcfg_next;
    logic                                 tcfg_wr;
    logic                                 ticlr_wr;
    logic                                 count_zero;

    always_comb begin
        tcfg_rdata = '0;
        tcfg_rdata[tcfg_en] = en;
        tcfg_rdata[tcfg_periodic] = periodic;
        tcfg_rdata[tcfg_initval_hi:tcfg_initval_lo] = initval;
    end

    assign tval_rdata = count;
    assign tcfg_next  = (csr_wmask & csr_wvalue) | (~csr_wmask & tcfg_rdata);
    assign tcfg_wr    = csr_we && csr_num == csr_tcfg;
    assign ticlr_wr   = csr_we && csr_num == csr_ticlr
                        && csr_wmask[ticlr_clr] && csr_wvalue[ticlr_clr];
    assign count_zero = count == '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
        end else if (tcfg_wr) begin
            en       <= tcfg_next[tcfg_en];
            periodic <= tcfg_next[tcfg_periodic];
            initval  <= tcfg_next[tcfg_initval_hi:tcfg_initval_lo];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= timer_idle;
        end else if (tcfg_wr && tcfg_next[tcfg_en]) begin
            count <= {tcfg_next[tcfg_initval_hi:tcfg_initval_lo], 2'b00}; // initval x4
        end else if (en && count != timer_idle) begin
            if (count_zero && periodic) begin
                count <= {initval, 2'b00};
            end else begin
                count <= count - 1'b1;  // one-shot wraps to idle
            end
        end
    end

    // set wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (count_zero) begin
            timer_int <= 1'b1;
        end else if (ticlr_wr) begin
            timer_int <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  wire                               clk,
    input  wire                               reset,
    input  wire  [csr_addr_pkg::csr_num_w-1:0] csr_num,
    input  wire                               csr_we,
    input  wire  [exc_pkg::xlen-1:0]          csr_wmask,
    input  wire  [exc_pkg::xlen-1:0]          csr_wvalue,
    input  wire  [exc_pkg::xlen-1:0]          crmd_rdata,
    input  wire  [exc_pkg::xlen-1:0]          prmd_rdata,
    input  wire  [exc_pkg::xlen-1:0]          ecfg_rdata,
    input  wire  [exc_pkg::xlen-1:0]          estat_rdata,
    input  wire  [exc_pkg::xlen-1:0]          badv_rdata,
    input  wire  [exc_pkg::xlen-1:0]          ertn_entry,
    input  wire  [exc_pkg::xlen-1:0]          tcfg_rdata,
    input  wire  [exc_pkg::xlen-1:0]          tval_rdata,
    output logic [exc_pkg::xlen-1:0]          csr_rvalue,
    output logic [exc_pkg::xlen-1:0]          ex_entry
);
    import csr_addr_pkg::*;
    import exc_pkg::*;

    logic [eentry_va_hi:eentry_va_lo] eentry_va;
    logic [xlen-1:0]                  save [4];
    logic [xlen-1:0]                  tid;
    logic [3:0]                       save_wr;

    assign ex_entry = {eentry_va, {eentry_va_lo{1'b0}}}; // 64-byte aligned

    assign save_wr[0] = csr_we && csr_num == csr_save0;
    assign save_wr[1] = csr_we && csr_num == csr_save1;
    assign save_wr[2] = csr_we && csr_num == csr_save2;
    assign save_wr[3] = csr_we && csr_num == csr_save3;

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va <= '0;
            tid       <= '0;
        end else if (csr_we) begin
            if (csr_num == csr_eentry) begin
                eentry_va <= (csr_wmask[eentry_va_hi:eentry_va_lo]
                              & csr_wvalue[eentry_va_hi:eentry_va_lo])
                             | (~csr_wmask[eentry_va_hi:eentry_va_lo] & eentry_va);
            end
            if (csr_num == csr_tid) begin
                tid <= (csr_wmask & csr_wvalue) | (~csr_wmask & tid);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (reset) begin
                save[i] <= '0;
            end else if (save_wr[i]) begin
                save[i] <= (csr_wmask & csr_wvalue) | (~csr_wmask & save[i]);
            end
        end
    end

    // read port returns the old value during a write
    always_comb begin
        case (csr_num)
            csr_crmd:   csr_rvalue = crmd_rdata;
            csr_prmd:   csr_rvalue = prmd_rdata;
            csr_ecfg:   csr_rvalue = ecfg_rdata;
            csr_estat:  csr_rvalue = estat_rdata;
            csr_era:    csr_rvalue = ertn_entry;
            csr_badv:   csr_rvalue = badv_rdata;
            csr_eentry: csr_rvalue = ex_entry;
            csr_save0:  csr_rvalue = save[0];
            csr_save1:  csr_rvalue = save[1];
            csr_save2:  csr_rvalue = save[2];
            csr_save3:  csr_rvalue = save[3];
            csr_tid:    csr_rvalue = tid;
            csr_tcfg:   csr_rvalue = tcfg_rdata;
            csr_tval:   csr_rvalue = tval_rdata;
            csr_ticlr:  csr_rvalue = '0;        // write-only clear
            default:    csr_rvalue = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top (
    input  wire                                clk,
    input  wire                                reset,
    input  wire  [csr_addr_pkg::csr_num_w-1:0] csr_num,
    input  wire                                csr_we,
    input  wire  [exc_pkg::xlen-1:0]           csr_wmask,
    input  wire  [exc_pkg::xlen-1:0]           csr_wvalue,
    input  wire                                wb_ex,
    input  wire                                ertn_flush,
    input  wire  [exc_pkg::ecode_w-1:0]        wb_ecode,
    input  wire  [exc_pkg::esubcode_w-1:0]     wb_esubcode,
    input  wire  [exc_pkg::xlen-1:0]           wb_pc,
    input  wire  [exc_pkg::xlen-1:0]           wb_vaddr,
    output wire  [exc_pkg::xlen-1:0]           csr_rvalue,
    output wire  [exc_pkg::xlen-1:0]           ex_entry,
    output wire  [exc_pkg::xlen-1:0]           ertn_entry,
    output wire                                has_int,
    output wire  [exc_pkg::plv_w-1:0]          crmd_plv
);
    import exc_pkg::*;

    wire [xlen-1:0] crmd_rdata;
    wire [xlen-1:0] prmd_rdata;
    wire [xlen-1:0] ecfg_rdata;
    wire [xlen-1:0] estat_rdata;
    wire [xlen-1:0] badv_rdata;
    wire [xlen-1:0] tcfg_rdata;
    wire [xlen-1:0] tval_rdata;
    wire            timer_int;

    exc_ctrl u_exc_ctrl (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .timer_int   (timer_int),
        .crmd_rdata  (crmd_rdata),
        .prmd_rdata  (prmd_rdata),
        .ecfg_rdata  (ecfg_rdata),
        .estat_rdata (estat_rdata),
        .badv_rdata  (badv_rdata),
        .ertn_entry  (ertn_entry),
        .crmd_plv    (crmd_plv),
        .has_int     (has_int)
    );

    csr_timer u_csr_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .tcfg_rdata (tcfg_rdata),
        .tval_rdata (tval_rdata),
        .timer_int  (timer_int)
    );

    csr_regfile u_csr_regfile (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .crmd_rdata  (crmd_rdata),
        .prmd_rdata  (prmd_rdata),
        .ecfg_rdata  (ecfg_rdata),
        .estat_rdata (estat_rdata),
        .badv_rdata  (badv_rdata),
        .ertn_entry  (ertn_entry),
        .tcfg_rdata  (tcfg_rdata),
        .tval_rdata  (tval_rdata),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry)
    );

endmodule

`default_nettype wire

// File: tb_csr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr;
    import csr_addr_pkg::*;

    localparam int clk_period      = 10;
    localparam int cycles_per_line = 20;
    localparam int reset_cycles    = 2;

    logic        clk;
    logic        reset;
    logic [13:0] csr_num;
    logic        csr_we;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic        wb_ex;
    logic        ertn_flush;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [31:0] wb_vaddr;
    wire  [31:0] csr_rvalue;
    wire  [31:0] ex_entry;
    wire  [31:0] ertn_entry;
    wire         has_int;
    wire  [1:0]  crmd_plv;

    // one entry per trace line
    logic [8*24-1:0] trace_name [$];
    logic [7:0]      trace_op [$];
    logic [31:0]     trace_f0 [$];
    logic [31:0]     trace_f1 [$];
    logic [31:0]     trace_f2 [$];
    logic [31:0]     trace_f3 [$];

    int   max_wait;     // largest T bound in the trace
    int   wd_limit;
    logic trace_ready;
    int   errors;
    int   checks;

    csr_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .has_int     (has_int),
        .crmd_plv    (crmd_plv)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic load_trace(output logic ok);
        int               fd;
        int               code;
        logic [8*160-1:0] line;
        logic [8*24-1:0]  name;
        logic [7:0]       op;
        logic [31:0]      f0, f1, f2, f3;
        ok = 1'b0;
        max_wait = 0;
        fd = $fopen("csr_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            code = $fgets(line, fd);
            while (code != 0) begin
                name = '0;
                code = $sscanf(line, "%s %s %h %h %h %h", name, op, f0, f1, f2, f3);
                if (code == 6 && name != "#") begin
                    trace_name.push_back(name);
                    trace_op.push_back(op);
                    trace_f0.push_back(f0);
                    trace_f1.push_back(f1);
                    trace_f2.push_back(f2);
                    trace_f3.push_back(f3);
                    if (op == "T" && int'(f0) > max_wait) begin
                        max_wait = int'(f0);
                    end
                end else if (code > 0 && name != "#") begin
                    $display("error: malformed trace line: %0s", line);
                    errors++;
                end
                code = $fgets(line, fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_word(input logic [8*24-1:0] name, input logic [8*12-1:0] what,
                                input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("mismatch %0s %0s: expected %h, actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic release_controls();
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
    endtask

    // each op starts 1 ns after an edge and checks at the falling edge
    task automatic run_entry(input int idx);
        logic [8*24-1:0] name;
        logic [7:0]      op;
        logic [31:0]     f0, f1, f2, f3;
        int              waited;
        logic            seen;
        name = trace_name[idx];
        op   = trace_op[idx];
        f0   = trace_f0[idx];
        f1   = trace_f1[idx];
        f2   = trace_f2[idx];
        f3   = trace_f3[idx];
        @(posedge clk);
        #1;
        release_controls();
        if (op == "W") begin
            csr_num    = f0[13:0];
            csr_wmask  = f1;
            csr_wvalue = f2;
            csr_we     = 1'b1;
        end else if (op == "R") begin
            csr_num = f0[13:0];
            @(negedge clk);
            compare_word(name, "rvalue", f1, csr_rvalue);
            if (f0[13:0] == csr_era) begin
                compare_word(name, "ertn_entry", f1, ertn_entry); // era mirrors the output
            end
            if (f0[13:0] == csr_eentry) begin
                compare_word(name, "ex_entry", f1, ex_entry);
            end
        end else if (op == "X") begin
            wb_ecode    = f0[5:0];
            wb_esubcode = f1[8:0];
            wb_pc       = f2;
            wb_vaddr    = f3;
            wb_ex       = 1'b1;
        end else if (op == "E") begin
            ertn_flush = 1'b1;
        end else if (op == "P") begin
            @(negedge clk);
            compare_word(name, "has_int", f0, {31'b0, has_int});
            compare_word(name, "crmd_plv", f1, {30'b0, crmd_plv});
        end else if (op == "T") begin
            seen   = 1'b0;
            waited = 0;
            while (!seen && waited < int'(f0)) begin
                @(negedge clk);
                waited++;
                if (has_int) begin
                    seen = 1'b1;
                end
            end
            checks++;
            if (!seen) begin
                $display("error: %0s interrupt never arrived within %0d cycles", name, f0);
                errors++;
            end
        end else begin
            $display("error: %0s has an unknown operation letter %s", name, op);
            errors++;
        end
    endtask

    initial begin
        logic ok;
        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        errors      = 0;
        checks      = 0;
        trace_ready = 1'b0;
        load_trace(ok);
        if (!ok) begin
            $display("error: could not open csr_trace.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            wd_limit = cycles_per_line * trace_name.size() + max_wait + reset_cycles + 2;
            trace_ready = 1'b1;
            repeat (reset_cycles) @(posedge clk);
            #1;
            reset = 1'b0;
            for (int i = 0; i < trace_name.size(); i++) begin
                run_entry(i);
            end
            @(posedge clk);
            #1;
            release_controls();
            $display("trace lines: %0d, checks: %0d, errors: %0d",
                     trace_name.size(), checks, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (trace_ready);
        repeat (wd_limit) @(posedge clk);
        $display("error: watchdog expired after %0d cycles, the trace did not finish", wd_limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_trace.txt
# test op f0 f1 f2 f3 (all fields hex, unused fields 0)
# W num mask value, R num expected, X ecode subcode pc vaddr, E, P has_int plv, T max_cycles
reset     R 0   8        0        0
reset     R 42  ffffffff 0        0
reset     P 0   0        0        0
masked    W 31  ffff0000 a1b2c3d4 0
masked    R 31  a1b20000 0        0
masked    W c   ffffffff 1c008fff 0
masked    R c   1c008fc0 0        0
masked    R 44  0        0        0
trap_ale  W 0   7        7        0
trap_ale  R 0   f        0        0
trap_ale  P 0   3        0        0
trap_ale  X 9   0        1c000100 80
trap_ale  P 0   0        0        0
trap_ale  R 0   8        0        0
trap_ale  R 1   7        0        0
trap_ale  R 6   1c000100 0        0
trap_ale  R 7   80       0        0
trap_ale  R 5   00090000 0        0
trap_ale  R c   1c008fc0 0        0
ertn      E 0   0        0        0
ertn      P 0   3        0        0
ertn      R 0   f        0        0
trap_ade  X 8   1        1c000200 1234
trap_ade  R 7   1234     0        0
trap_ade  R 5   00480000 0        0
trap_ade  R 1   7        0        0
trap_sys  X b   0        1c000300 5678
trap_sys  R 7   1234     0        0
trap_sys  R 6   1c000300 0        0
trap_sys  R 1   0        0        0
swi       W 0   7        4        0
swi       W 4   1fff     1        0
swi       W 5   3        1        0
swi       P 1   0        0        0
swi       R 5   000b0001 0        0
swi       W 4   1        0        0
swi       P 0   0        0        0
swi       W 4   1        1        0
swi       P 1   0        0        0
swi       W 0   4        0        0
swi       P 0   0        0        0
swi       W 0   4        4        0
swi       W 5   3        0        0
swi       P 0   0        0        0
oneshot   W 4   1fff     800      0
oneshot   W 41  ffffffff 11       0
oneshot   T 18  0        0        0
oneshot   R 42  ffffffff 0        0
oneshot   R 41  11       0        0
oneshot   R 5   000b0800 0        0
ticlr     W 44  1        1        0
ticlr     P 0   0        0        0
ticlr     R 5   000b0000 0        0
periodic  W 41  ffffffff b        0
periodic  T 18  0        0        0
periodic  R 41  b        0        0
periodic  W 44  1        1        0
periodic  P 0   0        0        0
periodic  T 18  0        0        0

// File: src.f
csr_addr_pkg.sv
exc_pkg.sv
exc_ctrl.sv
csr_timer.sv
csr_regfile.sv
csr_top.sv
tb_csr.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f src.f --top-module tb_csr -o tb_csr_sim --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_csr_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "no verdict found in sim.log"
    exit 1
fi
exit 0
